//--- hdl/femto_defines.svh
`ifndef FEMTO_DEFINES_SVH
`define FEMTO_DEFINES_SVH

// datapath widths
`define XLEN            32
`define BUS_WIDTH       32
`define ADDR_WIDTH      16
`define BUS_ACC_WIDTH   2

// addr[15:12] picks the region, low bits are the offset
`define REGION_WIDTH    4
`define REGION_RST      4'd0
`define REGION_SCR      4'd1

// reset domains: bit 0 core, bit 1 peripherals
`define RST_WIDTH       2
`define RST_VA_WIDTH    3

// access size codes
`define BUS_ACC_1B      2'd0
`define BUS_ACC_2B      2'd1
`define BUS_ACC_4B      2'd2

// reset cause byte values
`define RST_CAUSE_POR   8'h00
`define RST_CAUSE_HW    8'h01
`define RST_CAUSE_SW    8'h02

// reset controller register offsets
`define REG_RST         3'd0
`define REG_CAUSE       3'd2
`define REG_TAGVAL      3'd4

// scratch bank, four words
`define SCR_VA_WIDTH    4
`define SCR_NREGS       4

`endif

//--- hdl/femto_pkg.sv
`include "femto_defines.svh"

package femto_pkg;

    // one bus request, req is a single-cycle strobe
    typedef struct packed {
        logic                       req;
        logic [`ADDR_WIDTH-1:0]     addr;
        logic                       w_rb;   // 1 = read
        logic [`BUS_ACC_WIDTH-1:0]  acc;
        logic [`BUS_WIDTH-1:0]      wdata;
    } bus_req_t;

    // response, fault is same cycle as req, resp/rdata one later
    typedef struct packed {
        logic                   resp;
        logic                   fault;
        logic [`BUS_WIDTH-1:0]  rdata;
    } bus_rsp_t;

    // core trap decoding of the cause byte
    typedef struct packed {
        logic       is_bus;     // always 0 here
        logic [6:0] code;
    } trap_cause_t;

    // bus fault decoding of the cause byte
    typedef struct packed {
        logic       is_bus;     // always 1 here
        logic       w_rb;
        logic [1:0] region;
        logic [3:0] rsvd;       // reads as zero
    } bus_cause_t;

    // top bit tells the two views apart
    typedef union packed {
        trap_cause_t trap;
        bus_cause_t  bus;
    } fault_cause_u;

endpackage

//--- hdl/bus_decoder.sv
`include "femto_defines.svh"

module bus_decoder import femto_pkg::*; (
    input  logic                clk,
    input  logic                rst_ib,

    input  bus_req_t            bus_req,
    output logic                rst_req,
    output logic                scr_req,
    input  bus_rsp_t            rst_rsp,
    input  bus_rsp_t            scr_rsp,
    output bus_rsp_t            bus_rsp,

    output logic                bus_fault,
    output fault_cause_u        bus_fault_cause,
    output logic [`XLEN-1:0]    bus_fault_addr
);

    logic [`REGION_WIDTH-1:0]   region;
    logic                       sel_rst;
    logic                       sel_scr;
    logic                       unmapped;
    logic                       fault_any;
    logic [1:0]                 sel_q;      // {scr, rst} owner of the next cycle
    fault_cause_u               cause;

    assign region   = bus_req.addr[`ADDR_WIDTH-1 -: `REGION_WIDTH];
    assign sel_rst  = (region == `REGION_RST);
    assign sel_scr  = (region == `REGION_SCR);

    assign rst_req  = bus_req.req & sel_rst;
    assign scr_req  = bus_req.req & sel_scr;
    assign unmapped = bus_req.req & ~sel_rst & ~sel_scr;

    // own miss plus whatever a target refuses
    assign fault_any = unmapped | rst_rsp.fault | scr_rsp.fault;

    // remember who accepted, an unmapped or refused request leaves this zero
    always_ff @(posedge clk) begin
        if (!rst_ib) begin
            sel_q <= 2'b00;
        end else begin
            sel_q <= {scr_req & ~scr_rsp.fault, rst_req & ~rst_rsp.fault};
        end
    end

    // targets hold stale rdata, so only the owner gets through
    always_comb begin
        bus_rsp.resp  = rst_rsp.resp | scr_rsp.resp;
        bus_rsp.fault = fault_any;
        bus_rsp.rdata = ({`BUS_WIDTH{sel_q[0]}} & rst_rsp.rdata)
                      | ({`BUS_WIDTH{sel_q[1]}} & scr_rsp.rdata);
    end

    // bus view of the cause byte
    always_comb begin
        cause.bus.is_bus = 1'b1;
        cause.bus.w_rb   = bus_req.w_rb;
        cause.bus.region = region[1:0];
        cause.bus.rsvd   = 4'b0000;
    end

    assign bus_fault       = fault_any;
    assign bus_fault_cause = cause;
    assign bus_fault_addr  = {{(`XLEN-`ADDR_WIDTH){1'b0}}, bus_req.addr};

endmodule

//--- hdl/fault_monitor.sv
`include "femto_defines.svh"

module fault_monitor import femto_pkg::*; (
    input  logic                clk,
    input  logic                rst_ib,

    // core side
    input  logic                trap,
    input  logic [6:0]          trap_code,
    input  logic [`XLEN-1:0]    trap_pc,

    // from the decoder
    input  logic                bus_fault,
    input  fault_cause_u        bus_fault_cause,
    input  logic [`XLEN-1:0]    bus_fault_addr,

    // one event per cycle to the reset controller
    output logic                soc_fault,
    output logic [7:0]          soc_fault_cause,
    output logic [`XLEN-1:0]    soc_fault_addr
);

    fault_cause_u trap_cause;

    // trap view, is_bus stays clear
    always_comb begin
        trap_cause.trap.is_bus = 1'b0;
        trap_cause.trap.code   = trap_code;
    end

    always_ff @(posedge clk) begin
        if (!rst_ib) begin
            soc_fault <= 1'b0;
        end else begin
            soc_fault <= trap | bus_fault;
        end
    end

    // core trap wins over a bus fault in the same cycle
    always_ff @(posedge clk) begin
        if (trap) begin
            soc_fault_cause <= trap_cause;
            soc_fault_addr  <= trap_pc;     // pc of the trapping insn
        end else if (bus_fault) begin
            soc_fault_cause <= bus_fault_cause;
            soc_fault_addr  <= bus_fault_addr;
        end
    end

endmodule

//--- hdl/rst_controller.sv
`include "femto_defines.svh"

module rst_controller (
    input  logic                        clk,

    input  logic                        rst_ib,     // external, active low
    output logic [`RST_WIDTH-1:0]       rst_ob,     // per domain, active low

    input  logic                        soc_fault,
    input  logic [7:0]                  soc_fault_cause,
    input  logic [`XLEN-1:0]            soc_fault_addr,

    input  logic [`RST_VA_WIDTH-1:0]    addr,
    input  logic                        w_rb,
    input  logic [`BUS_ACC_WIDTH-1:0]   acc,
    input  logic [`BUS_WIDTH-1:0]       wdata,
    input  logic                        req,
    output logic [`BUS_WIDTH-1:0]       rdata,
    output logic                        resp,
    output logic                        fault
);

    // register map
    //   RST     0  2B  W   bit 0 requests a reset of all domains
    //   CAUSE   2  2B  R   cause byte in bits 7:0
    //   TAGVAL  4  4B  R   trap pc or faulting bus address

    logic                   invld_addr;
    logic                   invld_acc;
    logic                   invld_dir;
    logic                   invld;
    logic                   acc_ok;
    logic                   sw_rst;
    logic [7:0]             cause_q;
    logic [`XLEN-1:0]       tagval_q;
    logic                   resp_q;
    logic [`RST_WIDTH-1:0]  rst_q;

    assign invld_addr = (addr != `REG_RST) && (addr != `REG_CAUSE) && (addr != `REG_TAGVAL);
    assign invld_acc  = (addr == `REG_TAGVAL) ? (acc != `BUS_ACC_4B) : (acc != `BUS_ACC_2B);
    assign invld_dir  = (addr == `REG_RST) ? w_rb : ~w_rb;   // RST write only, rest read only
    assign invld      = invld_addr | invld_acc | invld_dir;

    assign fault  = req & invld;
    assign acc_ok = req & ~invld;

    // only a valid write can land here, and that is RST
    assign sw_rst = acc_ok & ~w_rb & wdata[0];

    // last reset cause, hw beats sw beats soc fault
    always_ff @(posedge clk) begin
        if (!rst_ib) begin
            cause_q  <= `RST_CAUSE_HW;
            tagval_q <= '0;                     // hw reset carries no tag
        end else if (sw_rst) begin
            cause_q  <= `RST_CAUSE_SW;
        end else if (soc_fault) begin
            cause_q  <= soc_fault_cause;
            tagval_q <= soc_fault_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_ib) begin
            resp_q <= 1'b0;
        end else begin
            resp_q <= acc_ok;
        end
    end

    // read data for the response cycle
    always_ff @(posedge clk) begin
        if (acc_ok && w_rb) begin
            if (addr == `REG_CAUSE) begin
                rdata <= {{(`BUS_WIDTH-8){1'b0}}, cause_q};
            end else begin
                rdata <= tagval_q;
            end
        end
    end

    assign resp = resp_q;

    // one-cycle low pulse on every domain per event
    always_ff @(posedge clk) begin
        if (!rst_ib) begin
            rst_q <= '0;
        end else if (sw_rst || soc_fault) begin
            rst_q <= '0;
        end else begin
            rst_q <= '1;
        end
    end

    assign rst_ob = rst_q;

endmodule

//--- hdl/scratch_regs.sv
`include "femto_defines.svh"

module scratch_regs (
    input  logic                        clk,
    input  logic                        rst_ib,     // peripheral domain reset

    input  logic [`SCR_VA_WIDTH-1:0]    addr,
    input  logic                        w_rb,
    input  logic [`BUS_ACC_WIDTH-1:0]   acc,
    input  logic [`BUS_WIDTH-1:0]       wdata,
    input  logic                        req,
    output logic [`BUS_WIDTH-1:0]       rdata,
    output logic                        resp,
    output logic                        fault
);

    logic [`BUS_WIDTH-1:0]      regs_q [`SCR_NREGS];
    logic [`SCR_VA_WIDTH-3:0]   idx;
    logic                       invld;
    logic                       hit;
    logic                       resp_q;

    assign idx = addr[`SCR_VA_WIDTH-1:2];     // word index

    // words only, and word aligned
    assign invld = (acc != `BUS_ACC_4B) || (addr[1:0] != 2'b00);
    assign fault = req & invld;
    assign hit   = req & ~invld;

    // contents are part of the peripheral domain
    always_ff @(posedge clk) begin
        if (!rst_ib) begin
            regs_q <= '{default: '0};
            resp_q <= 1'b0;
        end else begin
            resp_q <= hit;
            if (hit && !w_rb) begin
                regs_q[idx] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit && w_rb) begin
            rdata <= regs_q[idx];
        end
    end

    assign resp = resp_q;

endmodule

//--- hdl/femto_rst_sys.sv
`include "femto_defines.svh"

module femto_rst_sys import femto_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_ib,

    input  bus_req_t                bus_req,
    output bus_rsp_t                bus_rsp,

    input  logic                    trap,
    input  logic [6:0]              trap_code,
    input  logic [`XLEN-1:0]        trap_pc,

    output logic [`RST_WIDTH-1:0]   rst_ob
);

    logic               rst_req;
    logic               scr_req;
    wire bus_rsp_t      rst_rsp;    // fields come from separate ports
    wire bus_rsp_t      scr_rsp;
    logic               bus_fault;
    fault_cause_u       bus_fault_cause;
    logic [`XLEN-1:0]   bus_fault_addr;
    logic               soc_fault;
    logic [7:0]         soc_fault_cause;
    logic [`XLEN-1:0]   soc_fault_addr;

    bus_decoder u_dec (
        .clk            (clk),
        .rst_ib         (rst_ib),
        .bus_req        (bus_req),
        .rst_req        (rst_req),
        .scr_req        (scr_req),
        .rst_rsp        (rst_rsp),
        .scr_rsp        (scr_rsp),
        .bus_rsp        (bus_rsp),
        .bus_fault      (bus_fault),
        .bus_fault_cause(bus_fault_cause),
        .bus_fault_addr (bus_fault_addr)
    );

    fault_monitor u_fmon (
        .clk            (clk),
        .rst_ib         (rst_ib),
        .trap           (trap),
        .trap_code      (trap_code),
        .trap_pc        (trap_pc),
        .bus_fault      (bus_fault),
        .bus_fault_cause(bus_fault_cause),
        .bus_fault_addr (bus_fault_addr),
        .soc_fault      (soc_fault),
        .soc_fault_cause(soc_fault_cause),
        .soc_fault_addr (soc_fault_addr)
    );

    rst_controller u_rstc (
        .clk            (clk),
        .rst_ib         (rst_ib),
        .rst_ob         (rst_ob),
        .soc_fault      (soc_fault),
        .soc_fault_cause(soc_fault_cause),
        .soc_fault_addr (soc_fault_addr),
        .addr           (bus_req.addr[`RST_VA_WIDTH-1:0]),
        .w_rb           (bus_req.w_rb),
        .acc            (bus_req.acc),
        .wdata          (bus_req.wdata),
        .req            (rst_req),
        .rdata          (rst_rsp.rdata),
        .resp           (rst_rsp.resp),
        .fault          (rst_rsp.fault)
    );

    // scratch bank sits in the peripheral domain
    scratch_regs u_scr (
        .clk            (clk),
        .rst_ib         (rst_ob[1]),
        .addr           (bus_req.addr[`SCR_VA_WIDTH-1:0]),
        .w_rb           (bus_req.w_rb),
        .acc            (bus_req.acc),
        .wdata          (bus_req.wdata),
        .req            (scr_req),
        .rdata          (scr_rsp.rdata),
        .resp           (scr_rsp.resp),
        .fault          (scr_rsp.fault)
    );

endmodule

//--- verif/femto_rst_chk.sv
`include "femto_defines.svh"

module femto_rst_chk import femto_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_ib,
    input  bus_req_t                bus_req,
    input  bus_rsp_t                bus_rsp,
    input  logic                    soc_fault,
    input  logic [`RST_WIDTH-1:0]   rst_ob
);

    int unsigned fail_cnt = 0;      // read by the testbench
    logic        sw_rst;

    // accepted write of bit 0 to the RST register
    assign sw_rst = bus_req.req && !bus_rsp.fault && !bus_req.w_rb && bus_req.wdata[0]
                  && (bus_req.addr[`ADDR_WIDTH-1 -: `REGION_WIDTH] == `REGION_RST)
                  && (bus_req.addr[`RST_VA_WIDTH-1:0] == `REG_RST);

    resp_after_req: assert property (@(posedge clk) disable iff (!rst_ib)
        !bus_req.req |=> !bus_rsp.resp)
        else begin $error("resp without a request in the cycle before"); fail_cnt++; end

    rst_pulse_low: assert property (@(posedge clk) disable iff (!rst_ib)
        rst_ib && (sw_rst || soc_fault) |=> rst_ob == '0)
        else begin $error("reset event did not pull all domains low"); fail_cnt++; end

    rst_back_high: assert property (@(posedge clk) disable iff (!rst_ib)
        rst_ib && !(sw_rst || soc_fault) |=> rst_ob == '1)
        else begin $error("reset domains stayed low without an event"); fail_cnt++; end

    no_fault_with_resp: assert property (@(posedge clk) disable iff (!rst_ib)
        !(bus_rsp.fault && bus_rsp.resp))
        else begin $error("fault and resp high together"); fail_cnt++; end

endmodule

bind femto_rst_sys femto_rst_chk u_chk (
    .clk        (clk),
    .rst_ib     (rst_ib),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .soc_fault  (soc_fault),
    .rst_ob     (rst_ob)
);

//--- verif/femto_rst_tb.sv
`include "femto_defines.svh"

module femto_rst_tb import femto_pkg::*; ();

    localparam int N_RAND = 48;
    localparam int N_OPS  = N_RAND + 32;

    typedef struct packed {
        logic                   fault;
        logic                   rd;
        logic [`BUS_WIDTH-1:0]  rdata;
    } exp_rsp_t;

    logic                   clk;
    logic                   rst_ib;
    bus_req_t               bus_req;
    bus_rsp_t               bus_rsp;
    logic                   trap;
    logic [6:0]             trap_code;
    logic [`XLEN-1:0]       trap_pc;
    logic [`RST_WIDTH-1:0]  rst_ob;

    // reference model state
    logic [7:0]             m_cause;
    logic [`XLEN-1:0]       m_tagval;
    logic [`BUS_WIDTH-1:0]  m_scr [`SCR_NREGS];
    int                     m_pulses;

    exp_rsp_t               cur_exp;
    exp_rsp_t               due_exp;
    logic                   resp_due;
    int                     low_cnt;    // rst_ob low cycles seen
    integer                 seed;

    femto_rst_sys DUT (
        .clk        (clk),
        .rst_ib     (rst_ib),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .trap       (trap),
        .trap_code  (trap_code),
        .trap_pc    (trap_pc),
        .rst_ob     (rst_ob)
    );

    always #10 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    function automatic logic [`ADDR_WIDTH-1:0] rst_reg(input logic [`RST_VA_WIDTH-1:0] ofs);
        return {`REGION_RST, 9'd0, ofs};
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] scr_reg(input int idx);
        return {`REGION_SCR, 8'd0, idx[1:0], 2'b00};
    endfunction

    // every reset event clears the peripheral domain
    function automatic void model_reset(input logic [7:0] cause);
        m_cause  = cause;
        m_scr    = '{default: '0};
        m_pulses = m_pulses + 1;
    endfunction

    // expected response of one access, side effects go into the model
    function automatic exp_rsp_t model_access(input logic [`ADDR_WIDTH-1:0] addr,
                                              input logic w_rb, input logic [1:0] acc,
                                              input logic [`BUS_WIDTH-1:0] wdata);
        exp_rsp_t                   e;
        logic [`REGION_WIDTH-1:0]   region;
        logic [`RST_VA_WIDTH-1:0]   ofs;
        e      = '0;
        e.rd   = w_rb;
        region = addr[`ADDR_WIDTH-1 -: `REGION_WIDTH];
        ofs    = addr[`RST_VA_WIDTH-1:0];
        if (region == `REGION_RST) begin
            if (ofs == `REG_RST) e.fault = w_rb || (acc != `BUS_ACC_2B);
            else if (ofs == `REG_CAUSE) e.fault = !w_rb || (acc != `BUS_ACC_2B);
            else if (ofs == `REG_TAGVAL) e.fault = !w_rb || (acc != `BUS_ACC_4B);
            else e.fault = 1'b1;
            if (!e.fault) begin
                if (ofs == `REG_CAUSE) e.rdata = {24'd0, m_cause};
                else if (ofs == `REG_TAGVAL) e.rdata = m_tagval;
                else if (wdata[0]) model_reset(`RST_CAUSE_SW);
            end
        end else if (region == `REGION_SCR) begin
            e.fault = (acc != `BUS_ACC_4B) || (addr[1:0] != 2'b00);
            if (!e.fault && w_rb) e.rdata = m_scr[addr[3:2]];
            else if (!e.fault) m_scr[addr[3:2]] = wdata;
        end else begin
            e.fault = 1'b1;                 // unmapped region
        end
        if (e.fault) begin
            model_reset({1'b1, w_rb, region[1:0], 4'b0000});
            m_tagval = {16'd0, addr};
        end
        return e;
    endfunction

    task automatic bus_op(input logic [`ADDR_WIDTH-1:0] addr, input logic w_rb,
                          input logic [1:0] acc, input logic [`BUS_WIDTH-1:0] wdata);
        exp_rsp_t e;
        @(posedge clk);
        e = model_access(addr, w_rb, acc, wdata);
        cur_exp <= e;
        bus_req <= '{req: 1'b1, addr: addr, w_rb: w_rb, acc: acc, wdata: wdata};
        @(posedge clk);
        bus_req.req <= 1'b0;
        repeat (4) @(posedge clk);          // room for a reset pulse to settle
        check_value(low_cnt, m_pulses, "reset pulse count");
    endtask

    task automatic core_trap(input logic [6:0] code, input logic [`XLEN-1:0] pc);
        @(posedge clk);
        model_reset({1'b0, code});
        m_tagval = pc;
        trap      <= 1'b1;
        trap_code <= code;
        trap_pc   <= pc;
        @(posedge clk);
        trap <= 1'b0;
        repeat (4) @(posedge clk);
        check_value(low_cnt, m_pulses, "reset pulse count");
    endtask

    // fault in the request cycle, resp and rdata one cycle later
    always @(negedge clk) begin
        if (rst_ib) begin
            check_value(bus_rsp.fault, bus_req.req & cur_exp.fault, "fault flag");
            check_value(bus_rsp.resp, resp_due, "resp flag");
            if (resp_due && due_exp.rd) begin
                check_value(bus_rsp.rdata, due_exp.rdata, "read data");
            end
            check_value(DUT.u_chk.fail_cnt, 0, "assertion failure count");
            resp_due = bus_req.req & ~cur_exp.fault;
            due_exp  = cur_exp;
            if (rst_ob != '1) begin
                check_value(rst_ob, '0, "reset domains out of step");
                low_cnt = low_cnt + 1;
            end
        end
    end

    initial begin
        repeat (N_OPS * 10 + 200) @(posedge clk);
        $display("watchdog expired, the test run did not complete in time");
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        logic [31:0]            r;
        logic [`BUS_WIDTH-1:0]  wd;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [1:0]             acc;
        logic [6:0]             code;
        int                     i;
        clk       = 1'b0;
        rst_ib    = 1'b0;
        bus_req   = '0;
        trap      = 1'b0;
        trap_code = '0;
        trap_pc   = '0;
        cur_exp   = '0;
        due_exp   = '0;
        resp_due  = 1'b0;
        low_cnt   = 0;
        seed      = 32'h4b6ada3b;
        m_cause   = `RST_CAUSE_HW;
        m_tagval  = '0;
        m_scr     = '{default: '0};
        m_pulses  = 1;                      // pulse after release
        repeat (10) @(posedge clk);
        rst_ib <= 1'b1;

        bus_op(rst_reg(`REG_CAUSE), 1'b1, `BUS_ACC_2B, '0);
        bus_op(rst_reg(`REG_TAGVAL), 1'b1, `BUS_ACC_4B, '0);
        for (i = 0; i < `SCR_NREGS; i++) bus_op(scr_reg(i), 1'b1, `BUS_ACC_4B, '0);

        // scratch traffic with some bad sizes and unmapped regions mixed in
        for (i = 0; i < `SCR_NREGS; i++) bus_op(scr_reg(i), 1'b0, `BUS_ACC_4B, $random(seed));
        for (i = 0; i < N_RAND; i++) begin
            r    = $random(seed);
            wd   = $random(seed);
            addr = scr_reg(r[3:2]);
            acc  = `BUS_ACC_4B;
            if (r[7:4] == 4'd0) acc = r[9:8];
            if (r[7:4] == 4'd1) addr[15:12] = 4'd2 + r[11:10];
            bus_op(addr, r[12], acc, wd);
        end
        for (i = 0; i < `SCR_NREGS; i++) bus_op(scr_reg(i), 1'b1, `BUS_ACC_4B, '0);

        // software reset
        bus_op(scr_reg(2), 1'b0, `BUS_ACC_4B, 32'h5a5a_0f0f);
        bus_op(rst_reg(`REG_RST), 1'b0, `BUS_ACC_2B, 32'h1);
        bus_op(rst_reg(`REG_CAUSE), 1'b1, `BUS_ACC_2B, '0);
        bus_op(scr_reg(2), 1'b1, `BUS_ACC_4B, '0);

        // core trap, codes kept clear of the hw and sw causes
        r    = $random(seed);
        code = r[6:0];
        if (code < 7'h10) code = code + 7'h10;
        core_trap(code, $random(seed));
        bus_op(rst_reg(`REG_CAUSE), 1'b1, `BUS_ACC_2B, '0);
        bus_op(rst_reg(`REG_TAGVAL), 1'b1, `BUS_ACC_4B, '0);

        // bus faults
        bus_op(16'h3a48, 1'b1, `BUS_ACC_4B, '0);
        bus_op(rst_reg(`REG_CAUSE), 1'b1, `BUS_ACC_2B, '0);
        bus_op(rst_reg(`REG_TAGVAL), 1'b1, `BUS_ACC_4B, '0);
        bus_op(rst_reg(`REG_CAUSE), 1'b0, `BUS_ACC_2B, 32'hff);
        bus_op(rst_reg(`REG_CAUSE), 1'b1, `BUS_ACC_2B, '0);
        bus_op(rst_reg(`REG_RST), 1'b1, `BUS_ACC_2B, '0);
        bus_op(rst_reg(`REG_CAUSE), 1'b1, `BUS_ACC_2B, '0);
        bus_op(rst_reg(`REG_TAGVAL), 1'b1, `BUS_ACC_4B, '0);

        repeat (2) @(posedge clk);
        if (DUT.u_chk.fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "protocol assertions reported errors");
        end
    end

endmodule

//--- femto_rst.f
+incdir+hdl
hdl/femto_pkg.sv
hdl/bus_decoder.sv
hdl/fault_monitor.sv
hdl/rst_controller.sv
hdl/scratch_regs.sv
hdl/femto_rst_sys.sv
verif/femto_rst_chk.sv
verif/femto_rst_tb.sv
